// ==== hdl/addrDecode.sv ====
// ======================================
// registered memory map, request valid 1 clk after asn falls
// clears to rgnNone the clock after asn rises
// ======================================
`timescale 1ns/1ps
`include "sub_defines.svh"

module addrDecode (
    input  logic               clk,
    input  logic               rst,
    input  cpuBusPkg::busCycle cpuBus,
    output memMapPkg::memReq   req
);

    memMapPkg::region rgnNext;
    logic [2:0]       code;

    assign code = cpuBus.addr[19:17];   // 128kB blocks

    // map decode from the block code
    always_comb begin
        rgnNext = memMapPkg::rgnNone;              // codes 5..7 stay unmapped
        if (code <= `SUB_CODE_ROM_MAX) begin
            rgnNext = memMapPkg::rgnRom;           // 00'0000-05'ffff
        end else if (code == `SUB_CODE_RAM) begin
            rgnNext = memMapPkg::rgnRam;           // 06'0000
        end else if (code == `SUB_CODE_ROAD) begin
            // 08'0000 road RAM, 09'0000 road control
            rgnNext = cpuBus.addr[16] ? memMapPkg::rgnSio : memMapPkg::rgnRoad;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req <= '0;
        end else if (!cpuBus.asn) begin
            req.rgn      <= rgnNext;
            req.wordAddr <= cpuBus.addr[`SUB_ROM_AW:1];
            req.we       <= ~cpuBus.rnw;
            req.be       <= ~{cpuBus.udsn, cpuBus.ldsn};   // strobes are active low
            req.wdata    <= cpuBus.dout;
        end else begin
            req <= '0;   // no cycle, rgnNone
        end
    end

endmodule

// ==== hdl/cpuBusPkg.sv ====
// ======================================
// CPU side of the bus, strobes active low
// addr is a word address, byte lane comes from udsn/ldsn
// ======================================
package cpuBusPkg;

    // one snapshot of the 68000 bus pins
    typedef struct packed {
        logic [23:1] addr;    // word address
        logic        asn;     // address strobe
        logic        udsn;    // upper byte strobe, d15..d8
        logic        ldsn;    // lower byte strobe, d7..d0
        logic        rnw;     // 1 = read
        logic [15:0] dout;    // CPU write data
    } busCycle;

    // progress of one bus cycle in the DTACK logic
    typedef enum logic [1:0] {
        stIdle,   // waiting for a decoded request
        stWait,   // external select open, ok pending
        stAck     // dtackN low until asn rises
    } cycleState;

endpackage

// ==== hdl/cpuCenGen.sv ====
// ======================================
// fractional clock enable, cen and cenb alternate
// needs 2*num < den, each output pulses num times per den clocks
// ======================================
`timescale 1ns/1ps

module cpuCenGen (
    input  logic       clk,
    input  logic       rst,
    input  logic [6:0] num,   // runtime ratio numerator
    input  logic [7:0] den,   // runtime ratio denominator
    output logic       cen,
    output logic       cenb
);

    logic [7:0] acc;       // phase accumulator, always below den
    logic [8:0] sumNext;   // one bit wider for the compare
    logic       phase;     // 0 = next pulse goes to cen
    logic       wrap;

    // two pulses per CPU clock, hence twice num
    assign sumNext = {1'b0, acc} + {1'b0, num, 1'b0};
    assign wrap    = sumNext >= {1'b0, den};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc   <= '0;
            phase <= 1'b0;
            cen   <= 1'b0;
            cenb  <= 1'b0;
        end else begin
            if (wrap) begin
                // sum - den fits in 8 bits since acc < den
                acc   <= sumNext[7:0] - den;
                phase <= ~phase;
                cen   <= ~phase;   // first wrap after reset is cen
                cenb  <= phase;
            end else begin
                acc   <= sumNext[7:0];
                cen   <= 1'b0;
                cenb  <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/dtackGen.sv ====
// ======================================
// one bus cycle at a time, a new one starts only from stIdle
// ok strobes may stay low indefinitely, there is no timeout
// ======================================
`timescale 1ns/1ps
`include "sub_defines.svh"

module dtackGen (
    input  logic             clk,
    input  logic             rst,
    input  memMapPkg::memReq req,
    input  logic             asn,
    input  logic             romOk,
    input  logic [15:0]      romData,
    input  logic             ramOk,
    input  logic [15:0]      ramData,
    input  logic [15:0]      roadData,   // registered by the road memory
    output logic             romCs,
    output logic             ramCs,
    output logic             ramWe,
    output logic [15:0]      cpuDin,
    output logic             dtackN
);

    cpuBusPkg::cycleState state;
    logic                 asnQ;      // asn as seen by the decoder
    logic                 onChip;

    assign onChip = req.rgn == memMapPkg::rgnRoad || req.rgn == memMapPkg::rgnSio;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= cpuBusPkg::stIdle;
            asnQ   <= 1'b1;
            romCs  <= 1'b0;
            ramCs  <= 1'b0;
            ramWe  <= 1'b0;
            cpuDin <= '0;
            dtackN <= 1'b1;
        end else begin
            asnQ <= asn;
            case (state)
                cpuBusPkg::stIdle: begin
                    // req is live once the decoder has seen asn low too
                    if (!asn && !asnQ) begin
                        case (req.rgn)
                            memMapPkg::rgnRom: begin
                                romCs <= 1'b1;
                                state <= cpuBusPkg::stWait;
                            end
                            memMapPkg::rgnRam: begin
                                ramCs <= 1'b1;
                                ramWe <= req.we;
                                state <= cpuBusPkg::stWait;
                            end
                            memMapPkg::rgnRoad, memMapPkg::rgnSio:
                                state <= cpuBusPkg::stAck;   // data ready next clk
                            default: begin
                                cpuDin <= `SUB_OPEN_BUS;  // unmapped, ack right away
                                dtackN <= 1'b0;
                                state  <= cpuBusPkg::stAck;
                            end
                        endcase
                    end
                end
                cpuBusPkg::stWait: begin
                    if (romCs && romOk) begin
                        romCs  <= 1'b0;
                        cpuDin <= romData;
                        state  <= cpuBusPkg::stAck;
                    end else if (ramCs && ramOk) begin
                        ramCs  <= 1'b0;
                        ramWe  <= 1'b0;
                        cpuDin <= ramData;   // don't care on writes
                        state  <= cpuBusPkg::stAck;
                    end else if (req.rgn == memMapPkg::rgnNone) begin
                        romCs <= 1'b0;       // cycle dropped by the CPU
                        ramCs <= 1'b0;
                        ramWe <= 1'b0;
                        state <= cpuBusPkg::stIdle;
                    end
                end
                default: begin   // stAck
                    if (asn) begin
                        dtackN <= 1'b1;
                        state  <= cpuBusPkg::stIdle;
                    end else begin
                        dtackN <= 1'b0;
                        if (onChip) cpuDin <= roadData;
                    end
                end
            endcase
        end
    end

endmodule

// ==== hdl/memMapPkg.sv ====
// ======================================
// decoded memory request shared by decoder, DTACK logic and road memory
// wordAddr is sized for the widest port (ROM)
// ======================================
`include "sub_defines.svh"

package memMapPkg;

    // region hit by the current cycle
    typedef enum logic [2:0] {
        rgnNone,   // idle or unmapped
        rgnRom,
        rgnRam,
        rgnRoad,   // on-chip road RAM
        rgnSio     // serial/control registers
    } region;

    // registered decode of one CPU cycle
    typedef struct packed {
        region                  rgn;
        logic [`SUB_ROM_AW-1:0] wordAddr;   // CPU word address bits 18:1
        logic                   we;         // write cycle
        logic [1:0]             be;         // {upper, lower}, active high
        logic [15:0]            wdata;
    } memReq;

endpackage

// ==== hdl/roadMem.sv ====
// ======================================
// road RAM plus four control registers, byte writes on both
// reads are registered, no write-through on the same clock
// ======================================
`timescale 1ns/1ps
`include "sub_defines.svh"

module roadMem (
    input  logic             clk,
    input  logic             rst,
    input  memMapPkg::memReq req,
    output logic [15:0]      rdata
);

    localparam int Words = 1 << `SUB_ROAD_AW;

    logic [15:0]             mem [Words];
    logic [15:0]             sioReg [4];
    logic [`SUB_ROAD_AW-1:0] addr;
    logic [1:0]              sel;       // control register index
    logic                    roadWr;
    logic                    sioWr;

    assign addr   = req.wordAddr[`SUB_ROAD_AW-1:0];
    assign sel    = req.wordAddr[1:0];
    assign roadWr = req.rgn == memMapPkg::rgnRoad && req.we;
    assign sioWr  = req.rgn == memMapPkg::rgnSio && req.we;

    // road RAM, rewrites the same value while the cycle is held
    always_ff @(posedge clk) begin
        if (roadWr && req.be[1]) mem[addr][15:8] <= req.wdata[15:8];
        if (roadWr && req.be[0]) mem[addr][7:0]  <= req.wdata[7:0];
        rdata <= req.rgn == memMapPkg::rgnSio ? sioReg[sel] : mem[addr];
    end

    // serial/control bank
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                sioReg[i] <= '0;
            end
        end else if (sioWr) begin
            if (req.be[1]) sioReg[sel][15:8] <= req.wdata[15:8];
            if (req.be[0]) sioReg[sel][7:0]  <= req.wdata[7:0];
        end
    end

endmodule

// ==== hdl/subBusTop.sv ====
// ======================================
// sub-CPU bus side, the CPU core sits outside on cpuBus/cpuDin/dtackN
// ROM and RAM ports hold their select until ok, cen ratio from defines
// ======================================
`timescale 1ns/1ps
`include "sub_defines.svh"

module subBusTop (
    input  logic                   clk,
    input  logic                   rst,
    input  cpuBusPkg::busCycle     cpuBus,
    output logic                   cen,
    output logic                   cenb,
    // ROM port
    output logic                   romCs,
    output logic [`SUB_ROM_AW-1:0] romAddr,
    input  logic                   romOk,
    input  logic [15:0]            romData,
    // work RAM port
    output logic                   ramCs,
    output logic [`SUB_RAM_AW-1:0] ramAddr,
    output logic                   ramWe,
    output logic [1:0]             ramBe,
    output logic [15:0]            ramDout,
    input  logic                   ramOk,
    input  logic [15:0]            ramData,
    // back to the CPU
    output logic [15:0]            cpuDin,
    output logic                   dtackN
);

    memMapPkg::memReq req;
    logic [15:0]      roadData;

    assign romAddr = req.wordAddr[`SUB_ROM_AW-1:0];
    assign ramAddr = req.wordAddr[`SUB_RAM_AW-1:0];   // upper bits dropped
    assign ramBe   = req.be;
    assign ramDout = req.wdata;

    cpuCenGen u_cen (
        .clk    (clk),
        .rst    (rst),
        .num    (`SUB_CEN_NUM),   // ~10MHz from 50MHz
        .den    (`SUB_CEN_DEN),
        .cen    (cen),
        .cenb   (cenb)
    );

    addrDecode u_dec (
        .clk    (clk),
        .rst    (rst),
        .cpuBus (cpuBus),
        .req    (req)
    );

    dtackGen u_dtack (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .asn      (cpuBus.asn),
        .romOk    (romOk),
        .romData  (romData),
        .ramOk    (ramOk),
        .ramData  (ramData),
        .roadData (roadData),
        .romCs    (romCs),
        .ramCs    (ramCs),
        .ramWe    (ramWe),
        .cpuDin   (cpuDin),
        .dtackN   (dtackN)
    );

    roadMem u_road (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .rdata  (roadData)
    );

endmodule

// ==== include/sub_defines.svh ====
// ======================================
// shared widths, address codes and the default CPU clock ratio
// the ratio must satisfy 2*num < den so one wrap per clock at most
// ======================================
`ifndef SUB_DEFINES_SVH
`define SUB_DEFINES_SVH

// word address widths of the memory ports
`define SUB_ROM_AW   18
`define SUB_RAM_AW   16
`define SUB_ROAD_AW  11       // on-chip road RAM, 2k words

// codes seen on CPU address bits 19:17
`define SUB_CODE_ROM_MAX  3'd2   // 0..2 map to ROM
`define SUB_CODE_RAM      3'd3
`define SUB_CODE_ROAD     3'd4   // bit 16 picks road or sio

// default clock enable ratio, num/den of clk
`define SUB_CEN_NUM  7'd29
`define SUB_CEN_DEN  8'd146

// value seen by the CPU on unmapped reads
`define SUB_OPEN_BUS 16'hffff

`endif

// ==== tb.f ====
+incdir+include
hdl/cpuBusPkg.sv
hdl/memMapPkg.sv
hdl/cpuCenGen.sv
hdl/addrDecode.sv
hdl/dtackGen.sv
hdl/roadMem.sv
hdl/subBusTop.sv
test/subBusTb.sv

// ==== test/subBusTb.sv ====
// ========================================
// the testbench acts as the 68000 and ROM/RAM models answer in 0..5 clk
// sio registers are taken as zero after reset but road RAM is not cleared
// ========================================
`timescale 1ns/1ps
`include "sub_defines.svh"

module subBusTb;

    localparam int ClkPeriod  = 40;
    localparam int CycleLimit = 40;   // clocks to wait for DTACK
    localparam int BusCycles  = 40;   // upper bound on bus cycles run
    localparam int TimeoutCycles = 16 + BusCycles * (CycleLimit + 2)
                                 + 10 * int'(`SUB_CEN_DEN) + 200;

    logic                   clk;
    logic                   rst;
    cpuBusPkg::busCycle     cpuBus;
    logic                   cen, cenb;
    logic                   romCs, romOk;
    logic [`SUB_ROM_AW-1:0] romAddr;
    logic [15:0]            romData;
    logic                   ramCs, ramWe, ramOk;
    logic [`SUB_RAM_AW-1:0] ramAddr;
    logic [1:0]             ramBe;
    logic [15:0]            ramDout, ramData;
    logic [15:0]            cpuDin;
    logic                   dtackN;

    int                     errors = 0;
    logic [31:0]            lcgState = 32'h8e0c6b1e;
    logic                   okGiven;        // a model raised ok in this cycle
    logic                   csSeen;         // romCs or ramCs seen in this cycle
    logic [`SUB_ROM_AW-1:0] lastRomAddr;
    logic [`SUB_RAM_AW-1:0] lastRamAddr;
    logic [1:0]             lastRamBe;
    logic [15:0]            ramModel [int]; // sparse work RAM

    subBusTop uut (
        .clk     (clk),
        .rst     (rst),
        .cpuBus  (cpuBus),
        .cen     (cen),
        .cenb    (cenb),
        .romCs   (romCs),
        .romAddr (romAddr),
        .romOk   (romOk),
        .romData (romData),
        .ramCs   (ramCs),
        .ramAddr (ramAddr),
        .ramWe   (ramWe),
        .ramBe   (ramBe),
        .ramDout (ramDout),
        .ramOk   (ramOk),
        .ramData (ramData),
        .cpuDin  (cpuDin),
        .dtackN  (dtackN)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // ROM contents depend on every address bit
    function automatic logic [15:0] romWord(input logic [`SUB_ROM_AW-1:0] a);
        return a[15:0] ^ {a[17:16], 14'h0} ^ 16'h5aa5;
    endfunction

    function automatic logic [15:0] mergeBytes(input logic [15:0] old,
                                               input logic [15:0] wdata,
                                               input logic [1:0] be);
        return {be[1] ? wdata[15:8] : old[15:8], be[0] ? wdata[7:0] : old[7:0]};
    endfunction

    task automatic checkData(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkRegion(input string name, input memMapPkg::region got,
                               input memMapPkg::region exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %s expected %s",
                     $time, name, got.name(), exp.name());
        end
    endtask

    task automatic checkState(input string name, input cpuBusPkg::cycleState got,
                              input cpuBusPkg::cycleState exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %s expected %s",
                     $time, name, got.name(), exp.name());
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // ROM model
    initial begin
        int unsigned delay;
        romOk   = 1'b0;
        romData = '0;
        forever begin
            @(posedge clk);
            #2;
            if (romCs) begin
                lastRomAddr = romAddr;
                delay = (nextRand() >> 16) % 6;
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                romData = romWord(romAddr);
                romOk   = 1'b1;
                okGiven = 1'b1;
                @(posedge clk);
                #2;
                romOk = 1'b0;
            end
        end
    end

    // RAM model merges bytes on writes
    initial begin
        int unsigned delay;
        int          a;
        ramOk   = 1'b0;
        ramData = '0;
        forever begin
            @(posedge clk);
            #2;
            if (ramCs) begin
                a           = int'(ramAddr);
                lastRamAddr = ramAddr;
                lastRamBe   = ramBe;
                delay = (nextRand() >> 16) % 6;
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                if (ramWe) begin
                    ramModel[a] = mergeBytes(ramModel.exists(a) ? ramModel[a] : 16'h0,
                                             ramDout, ramBe);
                end
                ramData = ramModel.exists(a) ? ramModel[a] : 16'h0;
                ramOk   = 1'b1;
                okGiven = 1'b1;
                @(posedge clk);
                #2;
                ramOk = 1'b0;
            end
        end
    end

    // one CPU cycle with strobes released once DTACK is seen
    task automatic runCycle(input logic [23:0] byteAddr, input logic rnw,
                            input logic [1:0] be, input logic [15:0] wdata,
                            output logic [15:0] rdata);
        int waited;
        okGiven = 1'b0;
        csSeen  = 1'b0;
        waited  = 0;
        rdata   = 'x;
        cpuBus.addr = byteAddr[23:1];
        cpuBus.rnw  = rnw;
        cpuBus.dout = wdata;
        cpuBus.udsn = ~be[1];
        cpuBus.ldsn = ~be[0];
        cpuBus.asn  = 1'b0;
        do begin
            @(posedge clk);
            #2;
            csSeen = csSeen | romCs | ramCs;
            waited++;
        end while (dtackN && waited < CycleLimit);
        if (dtackN) begin
            errors++;
            $display("no DTACK within %0d clocks for address %h at %0t",
                     CycleLimit, byteAddr, $time);
        end else begin
            rdata = cpuDin;
            if (csSeen && !okGiven) begin
                errors++;
                $display("DTACK fell before the memory ok for address %h at %0t",
                         byteAddr, $time);
            end
        end
        cpuBus.asn  = 1'b1;
        cpuBus.udsn = 1'b1;
        cpuBus.ldsn = 1'b1;
        @(posedge clk);
        #2;
        checkCount("dtackN after release", int'(dtackN), 1);
        checkState("u_dtack.state", uut.u_dtack.state, cpuBusPkg::stIdle);
    endtask

    task automatic busRead(input logic [23:0] byteAddr, input logic [1:0] be,
                           output logic [15:0] data);
        runCycle(byteAddr, 1'b1, be, 16'h0000, data);
    endtask

    task automatic busWrite(input logic [23:0] byteAddr, input logic [1:0] be,
                            input logic [15:0] data);
        logic [15:0] ignored;
        runCycle(byteAddr, 1'b0, be, data, ignored);
    endtask

    task automatic resetValues();
        checkCount("romCs", int'(romCs), 0);
        checkCount("ramCs", int'(ramCs), 0);
        checkCount("ramWe", int'(ramWe), 0);
        checkCount("cen", int'(cen), 0);
        checkCount("dtackN", int'(dtackN), 1);
        checkRegion("u_dec.req.rgn", uut.u_dec.req.rgn, memMapPkg::rgnNone);
        checkState("u_dtack.state", uut.u_dtack.state, cpuBusPkg::stIdle);
    endtask

    task automatic romReads();
        logic [23:0] addrs [6] = '{24'h000000, 24'h01234a, 24'h02fffe,
                                   24'h04abc0, 24'h05fff0, 24'h03c002};
        logic [15:0] data;
        foreach (addrs[i]) begin
            busRead(addrs[i], 2'b11, data);
            checkCount("romAddr", int'(lastRomAddr), int'(addrs[i][18:1]));
            checkData("cpuDin rom", data, romWord(addrs[i][18:1]));
        end
    endtask

    task automatic ramBytes();
        logic [15:0] data;
        busWrite(24'h060100, 2'b11, 16'hdead);
        checkCount("ramBe full", int'(lastRamBe), 3);
        // word address cut to the RAM port width
        checkCount("ramAddr 060100", int'(lastRamAddr),
                   int'(24'h060100 >> 1) % (1 << `SUB_RAM_AW));
        busWrite(24'h060100, 2'b10, 16'h55ff);      // upper byte only
        checkCount("ramBe upper", int'(lastRamBe), 2);
        busWrite(24'h07fffe, 2'b11, 16'h1357);
        checkCount("ramAddr 07fffe", int'(lastRamAddr),
                   int'(24'h07fffe >> 1) % (1 << `SUB_RAM_AW));
        busWrite(24'h07fffe, 2'b01, 16'h229b);      // lower byte only
        checkCount("ramBe lower", int'(lastRamBe), 1);
        busRead(24'h060100, 2'b11, data);
        checkData("cpuDin ram 060100", data, mergeBytes(16'hdead, 16'h55ff, 2'b10));
        busRead(24'h07fffe, 2'b11, data);
        checkData("cpuDin ram 07fffe", data, mergeBytes(16'h1357, 16'h229b, 2'b01));
    endtask

    task automatic roadSio();
        logic [15:0] data;
        logic [15:0] sioExp [4] = '{default: 16'h0000};   // reset value
        busWrite(24'h08000a, 2'b11, 16'h1234);
        busWrite(24'h08000a, 2'b10, 16'hab99);
        busWrite(24'h080ffe, 2'b11, 16'h0f0f);
        busWrite(24'h080ffe, 2'b01, 16'h77c3);
        busRead(24'h08000a, 2'b11, data);
        checkData("cpuDin road 05", data, mergeBytes(16'h1234, 16'hab99, 2'b10));
        checkCount("selects on road cycle", int'(csSeen), 0);
        busRead(24'h080ffe, 2'b11, data);
        checkData("cpuDin road 7ff", data, mergeBytes(16'h0f0f, 16'h77c3, 2'b01));
        busWrite(24'h090002, 2'b10, 16'h5a00);
        sioExp[1] = mergeBytes(sioExp[1], 16'h5a00, 2'b10);
        busWrite(24'h090004, 2'b01, 16'h00a5);
        sioExp[2] = mergeBytes(sioExp[2], 16'h00a5, 2'b01);
        busWrite(24'h090006, 2'b11, 16'hbeef);
        sioExp[3] = mergeBytes(sioExp[3], 16'hbeef, 2'b11);
        busWrite(24'h090006, 2'b01, 16'h1201);
        sioExp[3] = mergeBytes(sioExp[3], 16'h1201, 2'b01);
        checkCount("selects on sio cycle", int'(csSeen), 0);
        for (int i = 0; i < 4; i++) begin
            busRead(24'h090000 + 24'(2 * i), 2'b11, data);
            checkData($sformatf("cpuDin sio %0d", i), data, sioExp[i]);
            checkCount("selects on sio read", int'(csSeen), 0);
        end
    endtask

    task automatic unmappedReads();
        logic [23:0] addrs [3] = '{24'h0a0000, 24'h0c0010, 24'h0e1234};
        logic [15:0] data;
        foreach (addrs[i]) begin
            busRead(addrs[i], 2'b11, data);
            checkData("cpuDin unmapped", data, `SUB_OPEN_BUS);
        end
    endtask

    task automatic cenRatio();
        int cenCount = 0;
        int cenbCount = 0;
        int lastPulse = 0;   // 1 for cen and 2 for cenb
        repeat (10 * int'(`SUB_CEN_DEN)) begin
            @(posedge clk);
            #2;
            if (cen && cenb) begin
                errors++;
                $display("cen and cenb high together at %0t", $time);
            end
            if (cen) begin
                if (lastPulse == 1) begin
                    errors++;
                    $display("two cen pulses without cenb between them at %0t", $time);
                end
                lastPulse = 1;
                cenCount++;
            end
            if (cenb) begin
                lastPulse = 2;
                cenbCount++;
            end
        end
        checkCount("cen pulses", cenCount, 10 * int'(`SUB_CEN_NUM));
        checkCount("cenb pulses", cenbCount, 10 * int'(`SUB_CEN_NUM));
    endtask

    // watchdog
    initial begin
        #(TimeoutCycles * ClkPeriod);
        $display("watchdog expired after %0d clocks, run stopped", TimeoutCycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        cpuBus = '0;
        cpuBus.asn  = 1'b1;
        cpuBus.udsn = 1'b1;
        cpuBus.ldsn = 1'b1;
        cpuBus.rnw  = 1'b1;
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;
        resetValues();
        romReads();
        ramBytes();
        roadSio();
        unmappedReads();
        cenRatio();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
